/* rtl/rv_pkg.sv */
package rv_pkg;

    // ******************************
    // Sizes
    // ******************************

    localparam int XLEN                = 32;
    localparam int IMEM_WORDS          = 256;
    localparam int IMEM_ADDR_BITS      = 8;    // Word index into the instruction memory.
    localparam int INSTR_BUF_SIZE      = 8;    // Depth of the fetch buffer in halfwords.
    localparam int INSTR_BUF_ADDR_SIZE = 3;    // A count is one bit wider than this.

    // Fetch starts here when reset is released.
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // ******************************
    // Shared structs
    // ******************************

    // One word access toward the instruction memory.
    // The loader and the fetch controller both use it.
    typedef struct packed {
        logic                      write;
        logic [IMEM_ADDR_BITS-1:0] addr;
        logic [XLEN-1:0]           wdata;
    } mem_req_t;

    // One instruction handed to decode.
    // A compressed instruction has a zero upper half.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } instr_out_t;

endpackage

/* rtl/rv_imem.sv */
`timescale 1ns/10ps

module rv_imem
(
    input  logic                        i_clk,
    input  logic                        i_en,
    input  rv_pkg::mem_req_t            i_mem,
    output logic [rv_pkg::XLEN-1:0]     o_rdata
);

    import rv_pkg::*;

    // Word storage. The program is written through the loader port.
    logic [XLEN-1:0] mem [IMEM_WORDS];

    // One port. A write leaves the read register untouched.
    always_ff @(posedge i_clk)
    begin
        if (i_en)
        begin
            if (i_mem.write)
                mem[i_mem.addr] <= i_mem.wdata;
            else
                o_rdata <= mem[i_mem.addr];    // Valid one cycle after the enable.
        end
    end

endmodule

/* rtl/rv_mem_arbiter.sv */
`timescale 1ns/10ps

module rv_mem_arbiter
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic [1:0]                  i_req,
    input  rv_pkg::mem_req_t [1:0]      i_req_data,
    output logic [1:0]                  o_ack,
    output logic                        o_mem_en,
    output rv_pkg::mem_req_t            o_mem,
    input  logic [rv_pkg::XLEN-1:0]     i_mem_rdata,
    output logic [rv_pkg::XLEN-1:0]     o_rdata
);

    import rv_pkg::*;

    typedef enum logic [1:0]
    {
        ARB_IDLE,
        ARB_GRANT,
        ARB_READ,
        ARB_ACK
    } arb_state_t;

    arb_state_t state;
    logic       last_served;    // Also selects the requester of the running access.
    logic       pick;

    // Requester 1 wins when it waits alone, or when both wait and 0 went last.
    assign pick = i_req[1] & (!i_req[0] | !last_served);

    // ******************************
    // Grant FSM
    // ******************************

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state       <= ARB_IDLE;
            last_served <= 1'b1;
            o_ack       <= '0;
        end
        else
        begin
            case (state)
                ARB_IDLE:
                    if (|i_req)
                    begin
                        last_served <= pick;
                        state       <= ARB_GRANT;
                    end
                ARB_GRANT:
                    state <= ARB_READ;    // Memory access happens at this edge.
                ARB_READ:
                begin
                    o_ack[last_served] <= 1'b1;
                    state              <= ARB_ACK;
                end
                ARB_ACK:
                    // Ack stays up until the requester lets go of req.
                    if (!i_req[last_served])
                    begin
                        o_ack <= '0;
                        state <= ARB_IDLE;
                    end
                default:
                    state <= ARB_IDLE;
            endcase
        end
    end

    // Read data is captured once and held for the whole ack phase.
    always_ff @(posedge i_clk)
    begin
        if (state == ARB_READ)
            o_rdata <= i_mem_rdata;
    end

    assign o_mem_en = (state == ARB_GRANT);
    assign o_mem    = i_req_data[last_served];

endmodule

/* rtl/rv_fetch_ctrl.sv */
`timescale 1ns/10ps

module rv_fetch_ctrl
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_redirect,
    input  logic [rv_pkg::XLEN-1:0]     i_redirect_pc,
    input  logic                        i_buf_room,
    input  logic [rv_pkg::XLEN-1:0]     i_pc_incr,
    input  logic                        i_mem_ack,
    input  logic [rv_pkg::XLEN-1:0]     i_mem_rdata,
    output logic                        o_mem_req,
    output rv_pkg::mem_req_t            o_mem,
    output logic                        o_buf_push,
    output logic [rv_pkg::XLEN-1:0]     o_buf_data,
    output logic                        o_fetch_pc1
);

    import rv_pkg::*;

    logic [XLEN-1:0] fetch_pc;
    logic            kill;     // Set when a redirect hits a request in flight.
    logic            done;
    logic            start;

    // The ack of the running request first shows while req is still high.
    assign done = o_mem_req & i_mem_ack;

    // A new request needs the previous handshake fully closed.
    assign start = !o_mem_req & !i_mem_ack & i_buf_room & !i_redirect;

    assign o_buf_push  = done & !kill & !i_redirect;
    assign o_buf_data  = i_mem_rdata;
    assign o_fetch_pc1 = fetch_pc[1];    // Stable from issue until the strobe.

    // ******************************
    // Fetch address
    // ******************************

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            fetch_pc <= RESET_PC;
        else if (i_redirect)
            fetch_pc <= {i_redirect_pc[XLEN-1:1], 1'b0};
        else if (o_buf_push)
            fetch_pc <= fetch_pc + i_pc_incr;    // 2 only after an odd restart.
    end

    // ******************************
    // Requester handshake
    // ******************************

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_mem_req <= 1'b0;
            kill      <= 1'b0;
        end
        else
        begin
            if (start)
                o_mem_req <= 1'b1;
            else if (done)
                o_mem_req <= 1'b0;

            if (done)
                kill <= 1'b0;
            else if (i_redirect & o_mem_req)
                kill <= 1'b1;
        end
    end

    // The request is frozen while req is up.
    always_ff @(posedge i_clk)
    begin
        if (start)
        begin
            o_mem.write <= 1'b0;
            o_mem.addr  <= fetch_pc[IMEM_ADDR_BITS+1:2];
            o_mem.wdata <= '0;
        end
    end

endmodule

/* rtl/rv_fetch_buf.sv */
`timescale 1ns/10ps

module rv_fetch_buf
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_pc_select,
    input  logic [rv_pkg::XLEN-1:0]     i_fetch_pc_next,
    input  logic                        i_ack,
    input  logic [rv_pkg::XLEN-1:0]     i_data,
    input  logic                        i_fetch_pc1,
    input  logic                        i_decode_ready,
    output logic                        o_free_dword_or_more,
    output logic [rv_pkg::XLEN-1:0]     o_pc_incr,
    output rv_pkg::instr_out_t          o_instr
);

    import rv_pkg::*;

    typedef logic [INSTR_BUF_ADDR_SIZE:0] cnt_t;

    logic [15:0]     buffer [INSTR_BUF_SIZE];
    cnt_t            cnt;
    cnt_t            cnt_after_pop;
    cnt_t            cnt_next;
    cnt_t            pop_cnt;
    cnt_t            push_cnt;
    logic [XLEN-1:0] pc;
    logic            fetch_pc1;
    logic            move;
    logic            out_valid;
    logic            empty;
    logic            full;
    logic            nearfull;
    logic            out_comp;
    logic            have_valid_instr;
    logic            push_double_word;
    logic            push_word;
    logic            pop_double_word;
    logic            pop_word;

    assign empty    = (cnt == '0);
    assign full     = (cnt == cnt_t'(INSTR_BUF_SIZE));
    assign nearfull = (cnt == cnt_t'(INSTR_BUF_SIZE - 1));

    // Low bits 11 at the head mark a 32-bit instruction.
    assign out_comp         = !(&buffer[0][1:0]);
    assign have_valid_instr = (out_comp & !empty) | (!out_comp & (cnt > cnt_t'(1)));

    // ******************************
    // Push, pop and count
    // ******************************

    assign push_double_word = i_ack & !full & !nearfull & !fetch_pc1;
    assign push_word        = i_ack & !full & fetch_pc1;    // Upper half only.
    assign pop_double_word  = move & !out_comp & !empty;
    assign pop_word         = move & out_comp & !empty;

    assign pop_cnt  = pop_double_word ? cnt_t'(2) : (pop_word ? cnt_t'(1) : '0);
    assign push_cnt = push_double_word ? cnt_t'(2) : (push_word ? cnt_t'(1) : '0);

    assign cnt_after_pop = cnt - pop_cnt;
    assign cnt_next      = i_pc_select ? '0 : cnt_after_pop + push_cnt;

    assign o_free_dword_or_more = (cnt_next < cnt_t'(INSTR_BUF_SIZE - 1));

    // Pushed halfwords land just behind what is left after this cycle's pop.
    for (genvar i = 0; i < INSTR_BUF_SIZE; i++)
    begin : gen_buf
        logic        update_hi;
        logic        update_lo;
        logic [15:0] shift_1;
        logic [15:0] shift_2;
        logic [15:0] next;

        assign update_hi = (push_word & (cnt_after_pop == cnt_t'(i))) |
                           (push_double_word & ((cnt_after_pop + cnt_t'(1)) == cnt_t'(i)));
        assign update_lo = push_double_word & (cnt_after_pop == cnt_t'(i));

        if (i + 1 < INSTR_BUF_SIZE)
        begin : gen_shift_1
            assign shift_1 = buffer[i + 1];
        end
        else
        begin : gen_shift_1_end
            assign shift_1 = '0;
        end

        if (i + 2 < INSTR_BUF_SIZE)
        begin : gen_shift_2
            assign shift_2 = buffer[i + 2];
        end
        else
        begin : gen_shift_2_end
            assign shift_2 = '0;
        end

        assign next = update_hi ? i_data[31:16] :
                      update_lo ? i_data[15:0] :
                      pop_word  ? shift_1 :
                      shift_2;

        always_ff @(posedge i_clk)
        begin
            if (update_hi | update_lo | pop_word | pop_double_word)
                buffer[i] <= next;
        end
    end

    // ******************************
    // Control registers and PC
    // ******************************

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            cnt       <= '0;
            fetch_pc1 <= 1'b0;
            move      <= 1'b0;
            pc        <= RESET_PC;
        end
        else
        begin
            cnt       <= cnt_next;
            fetch_pc1 <= i_fetch_pc1;    // Applies to the strobe one cycle later.
            // Never two moves in a row, the pop must land first.
            move      <= i_decode_ready & have_valid_instr & !move & !i_pc_select;
            if (i_pc_select)
                pc <= i_fetch_pc_next;
            else if (pop_double_word)
                pc <= pc + XLEN'(4);
            else if (pop_word)
                pc <= pc + XLEN'(2);
        end
    end

    // Only the first word after an odd restart carries a single halfword.
    assign o_pc_incr = (empty & i_fetch_pc1) ? XLEN'(2) : XLEN'(4);

    assign out_valid = move & !i_pc_select;    // A redirect drops the pending output.

    always_comb
    begin
        o_instr.valid        = out_valid;
        o_instr.pc           = pc;
        o_instr.instr[31:16] = (out_valid & !out_comp) ? buffer[1] : '0;
        o_instr.instr[15:0]  = out_valid ? buffer[0] : '0;
    end

endmodule

/* rtl/rv_frontend.sv */
`timescale 1ns/10ps

module rv_frontend
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_redirect,
    input  logic [rv_pkg::XLEN-1:0]     i_redirect_pc,
    input  logic                        i_decode_ready,
    input  logic                        i_load_req,
    input  rv_pkg::mem_req_t            i_load,
    output logic                        o_load_ack,
    output rv_pkg::instr_out_t          o_instr
);

    import rv_pkg::*;

    logic            fetch_req;
    mem_req_t        fetch_mem;
    logic            fetch_ack;
    logic [XLEN-1:0] arb_rdata;
    logic            buf_push;
    logic [XLEN-1:0] buf_data;
    logic            fetch_pc1;
    logic            buf_room;
    logic [XLEN-1:0] pc_incr;
    logic [1:0]      arb_req;
    mem_req_t [1:0]  arb_req_data;
    logic [1:0]      arb_ack;
    logic            mem_en;
    mem_req_t        mem_req;
    logic [XLEN-1:0] imem_rdata;

    // Port 0 is the loader, port 1 the fetch controller.
    assign arb_req      = {fetch_req, i_load_req};
    assign arb_req_data = {fetch_mem, i_load};
    assign o_load_ack   = arb_ack[0];
    assign fetch_ack    = arb_ack[1];

    rv_fetch_ctrl rv_fetch_ctrl_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_buf_room     (buf_room),
        .i_pc_incr      (pc_incr),
        .i_mem_ack      (fetch_ack),
        .i_mem_rdata    (arb_rdata),
        .o_mem_req      (fetch_req),
        .o_mem          (fetch_mem),
        .o_buf_push     (buf_push),
        .o_buf_data     (buf_data),
        .o_fetch_pc1    (fetch_pc1)
    );

    rv_fetch_buf rv_fetch_buf_inst
    (
        .i_clk                  (i_clk),
        .i_reset_n              (i_reset_n),
        .i_pc_select            (i_redirect),
        .i_fetch_pc_next        (i_redirect_pc),
        .i_ack                  (buf_push),
        .i_data                 (buf_data),
        .i_fetch_pc1            (fetch_pc1),
        .i_decode_ready         (i_decode_ready),
        .o_free_dword_or_more   (buf_room),
        .o_pc_incr              (pc_incr),
        .o_instr                (o_instr)
    );

    rv_mem_arbiter rv_mem_arbiter_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_req          (arb_req),
        .i_req_data     (arb_req_data),
        .o_ack          (arb_ack),
        .o_mem_en       (mem_en),
        .o_mem          (mem_req),
        .i_mem_rdata    (imem_rdata),
        .o_rdata        (arb_rdata)
    );

    rv_imem rv_imem_inst
    (
        .i_clk      (i_clk),
        .i_en       (mem_en),
        .i_mem      (mem_req),
        .o_rdata    (imem_rdata)
    );

endmodule

/* bench/rv_frontend_props.sv */
`timescale 1ns/10ps

module rv_frontend_props
(
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic [1:0]  i_req,
    input  logic [1:0]  i_ack
);

    // ******************************
    // Four-phase handshake rules
    // ******************************

    for (genvar k = 0; k < 2; k++)
    begin : gen_port
        req_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
            i_req[k] && !i_ack[k] |=> i_req[k])
            else $error("Requester %0d dropped req before its ack.", k);

        ack_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
            i_ack[k] && i_req[k] |=> i_ack[k])
            else $error("Ack %0d fell while req was still high.", k);

        ack_release: assert property (@(posedge i_clk) disable iff (!i_reset_n)
            i_ack[k] && !i_req[k] |=> !i_ack[k])
            else $error("Ack %0d stayed high after req dropped.", k);

        // A new request only after the last ack is gone.
        req_restart: assert property (@(posedge i_clk) disable iff (!i_reset_n)
            $rose(i_req[k]) |-> !i_ack[k])
            else $error("Requester %0d raised req while ack was high.", k);

        ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
            $rose(i_ack[k]) |-> i_req[k])
            else $error("Ack %0d rose without a request.", k);
    end

    ack_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $onehot0(i_ack))
        else $error("Both acks are high at once.");

endmodule

bind rv_mem_arbiter rv_frontend_props rv_frontend_props_inst
(
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_req      (i_req),
    .i_ack      (o_ack)
);

/* bench/tb_rv_frontend.sv */
`timescale 1ns/10ps

module tb_rv_frontend;

    import rv_pkg::*;

    localparam logic [31:0] SEED         = 32'h7adf_605f;
    localparam int          RESET_CYCLES = 16;
    localparam int          TOTAL_INSTRS = 260;              // Sum of all segments below.
    localparam int          LOAD_WORDS   = IMEM_WORDS + 32;
    localparam int          CYCLE_LIMIT  = 40 * TOTAL_INSTRS + 20 * LOAD_WORDS
                                           + 2 * RESET_CYCLES;
    localparam int          READY_LOW    = 0;
    localparam int          READY_HIGH   = 1;
    localparam int          READY_RANDOM = 2;

    logic            i_clk;
    logic            i_reset_n;
    logic            i_redirect;
    logic [XLEN-1:0] i_redirect_pc;
    logic            i_decode_ready;
    logic            i_load_req;
    mem_req_t        i_load;
    logic            o_load_ack;
    instr_out_t      o_instr;

    logic [15:0]     image [2 * IMEM_WORDS];    // Program image in halfwords.
    logic [31:0]     rnd = SEED;
    logic [XLEN-1:0] exp_pc = RESET_PC;
    logic [XLEN-1:0] exp_word;
    logic            ready_prev = 1'b0;
    int              ready_mode = READY_LOW;
    int              checked = 0;
    int              cycle_count = 0;

    rv_frontend rv_frontend_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_decode_ready (i_decode_ready),
        .i_load_req     (i_load_req),
        .i_load         (i_load),
        .o_load_ack     (o_load_ack),
        .o_instr        (o_instr)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Low bits 11 start a 32-bit instruction. Anything else is compressed.
    function automatic logic [31:0] expected_instr(input logic [XLEN-1:0] pc);
        logic [8:0]  idx;
        logic [15:0] low;
        idx = pc[9:1];
        low = image[idx];
        if (low[1:0] == 2'b11)
            return {image[idx + 9'd1], low};
        return {16'h0000, low};
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at %0t.", $time);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("MISMATCH at %0t: %s expected 0x%08h, actual 0x%08h",
                                    $time, name, expected, actual));
    endtask

    // ******************************
    // Stimulus tasks
    // ******************************

    task automatic load_word(input logic [IMEM_ADDR_BITS-1:0] addr, input logic [31:0] data);
        @(posedge i_clk);
        i_load_req   <= 1'b1;
        i_load.write <= 1'b1;
        i_load.addr  <= addr;
        i_load.wdata <= data;
        do
            @(negedge i_clk);
        while (!o_load_ack);
        @(posedge i_clk);
        i_load_req <= 1'b0;
        do
            @(negedge i_clk);    // Ack must fall before the next request.
        while (o_load_ack);
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] pc);
        @(posedge i_clk);
        i_redirect    <= 1'b1;
        i_redirect_pc <= pc;
        exp_pc = pc;
        @(posedge i_clk);
        i_redirect <= 1'b0;
    endtask

    task automatic wait_instrs(input int count);
        int target;
        target = checked + count;
        do
            @(negedge i_clk);
        while (checked < target);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever
            #50 i_clk = ~i_clk;
    end

    initial
    begin
        logic [31:0] ready_rnd;
        ready_rnd = lcg_next(SEED);
        i_decode_ready = 1'b0;
        forever
        begin
            @(posedge i_clk);
            ready_rnd = lcg_next(ready_rnd);
            if (ready_mode == READY_RANDOM)
                i_decode_ready <= (ready_rnd[18:16] > 3'd2);    // Random low gaps.
            else
                i_decode_ready <= (ready_mode == READY_HIGH);
        end
    end

    initial
    begin
        while (cycle_count <= CYCLE_LIMIT)
        begin
            @(posedge i_clk);
            cycle_count = cycle_count + 1;
        end
        stop_with_failure("Timeout: the run went past its cycle limit.");
    end

    // ******************************
    // Reference stream check
    // ******************************

    always @(negedge i_clk)
    begin
        if (i_reset_n)
        begin
            valid_after_ready: assert (!o_instr.valid || ready_prev)
                else stop_with_failure("An instruction came out without a ready cycle before it.");
            if (o_instr.valid)
            begin
                exp_word = expected_instr(exp_pc);
                pc_check: assert (o_instr.pc == exp_pc)
                    else report_mismatch("o_instr.pc", exp_pc, o_instr.pc);
                instr_check: assert (o_instr.instr == exp_word)
                    else report_mismatch("o_instr.instr", exp_word, o_instr.instr);
                exp_pc  = exp_pc + ((exp_word[1:0] == 2'b11) ? 32'd4 : 32'd2);
                checked = checked + 1;
            end
        end
        ready_prev = i_decode_ready;
    end

    initial
    begin
        int h;
        i_reset_n     = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_load_req    = 1'b0;
        i_load        = '0;

        h = 0;
        while (h < 2 * IMEM_WORDS)
        begin
            rnd = lcg_next(rnd);
            if (rnd[20] && h < 2 * IMEM_WORDS - 1)
            begin
                image[h] = {rnd[15:2], 2'b11};
                rnd = lcg_next(rnd);
                image[h + 1] = rnd[31:16];
                h = h + 2;
            end
            else
            begin
                image[h] = {rnd[15:2], (rnd[1:0] == 2'b11) ? 2'b01 : rnd[1:0]};
                h = h + 1;
            end
        end

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(negedge i_clk);
        reset_state: assert (!o_instr.valid && !o_load_ack)
            else stop_with_failure("o_instr.valid or o_load_ack is high after reset.");

        // Fetch has read an empty memory by now.
        // A second reset restarts it at the reset PC once the program is in.
        for (int w = 0; w < IMEM_WORDS; w++)
            load_word(w[IMEM_ADDR_BITS-1:0], {image[2 * w + 1], image[2 * w]});
        @(posedge i_clk);
        i_reset_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset_n <= 1'b1;
        ready_mode = READY_HIGH;
        wait_instrs(60);

        ready_mode = READY_RANDOM;
        wait_instrs(60);

        rnd = lcg_next(rnd);
        redirect_to({24'h0, rnd[21:16], 2'b10});    // Odd halfword target.
        wait_instrs(40);
        rnd = lcg_next(rnd);
        redirect_to({24'h0, rnd[21:16], 2'b00});
        wait_instrs(40);

        // The top words lie far above every fetch path.
        fork
            begin
                for (int w = 224; w < IMEM_WORDS; w++)
                begin
                    rnd = lcg_next(rnd);
                    image[2 * w]     = rnd[15:0];
                    image[2 * w + 1] = rnd[31:16];
                    load_word(w[IMEM_ADDR_BITS-1:0], rnd);
                end
            end
            wait_instrs(60);
        join

        @(negedge i_clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* rv_frontend.f */
rtl/rv_pkg.sv
rtl/rv_imem.sv
rtl/rv_mem_arbiter.sv
rtl/rv_fetch_ctrl.sv
rtl/rv_fetch_buf.sv
rtl/rv_frontend.sv
bench/rv_frontend_props.sv
bench/tb_rv_frontend.sv

/* Makefile */
SIM        := verilator
TOP        := tb_rv_frontend
FILELIST   := rv_frontend.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulator's exit status carries the result of the run.
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
